// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing
TOP       = cmd_uart_tb
FILELIST  = cmd_uart.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = ** PASS **

SRCS = $(shell grep -v '^+' $(FILELIST))
HDRS = $(wildcard common/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -Fqx '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== cmd_uart.f ====
+incdir+common
common/cmd_uart_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
hw/cmd_ctrl.sv
hw/cmd_uart_top.sv
tb/uart_peer.sv
tb/cmd_uart_tb.sv

// ==== common/cmd_uart_config.svh ====
`ifndef CMD_UART_CONFIG_SVH
`define CMD_UART_CONFIG_SVH

// clock cycles per serial bit, 434 for 50 MHz at 115200 baud
`define CMD_UART_CLKS_PER_BIT 16

// idle cycles on tx between the low and high command frames
`define CMD_UART_FRAME_GAP 100

// cycles to wait for a reply start bit, counted from rx_en rising
`define CMD_UART_RESP_TIMEOUT (64 * `CMD_UART_CLKS_PER_BIT)

`endif

// ==== common/cmd_uart_pkg.sv ====
package cmd_uart_pkg;

  typedef logic [7:0] uart_byte_t;

  // bit 15 write flag, 14:8 register address, 7:0 write data
  typedef struct packed {
    logic       wr;
    logic [6:0] addr;
    uart_byte_t data;
  } cmd_word_t;

  typedef enum logic [1:0] {
    RSP_OK         = 2'd0,
    RSP_PARITY_ERR = 2'd1,
    RSP_FRAME_ERR  = 2'd2,
    RSP_TIMEOUT    = 2'd3
  } rsp_status_t;

  // odd parity bit, data plus parity carries an odd count of ones
  function automatic logic odd_parity(input uart_byte_t b);
    return ~^b;
  endfunction

endpackage

// ==== hw/cmd_ctrl.sv ====
`timescale 1ns/100ps
`include "cmd_uart_config.svh"

module cmd_ctrl (
  input  logic                      clk,
  input  logic                      rst_n,
  input  cmd_uart_pkg::cmd_word_t   cmd_in,
  input  logic                      cmd_vld,
  input  logic                      tx_busy,
  input  logic                      tx_done,
  input  logic                      rx_start_seen,
  input  logic                      rx_valid,
  input  cmd_uart_pkg::uart_byte_t  rx_byte,
  input  logic                      rx_parity_err,
  input  logic                      rx_frame_err,
  output logic                      cmd_rdy,
  output logic                      tx_start,
  output cmd_uart_pkg::uart_byte_t  tx_byte,
  output logic                      rx_en,
  output logic                      rsp_valid,
  output cmd_uart_pkg::uart_byte_t  rsp_data,
  output cmd_uart_pkg::rsp_status_t rsp_status
);
  import cmd_uart_pkg::*;

  localparam int GAP     = `CMD_UART_FRAME_GAP;
  localparam int TIMEOUT = `CMD_UART_RESP_TIMEOUT;
  localparam int CNT_MAX = (TIMEOUT > GAP) ? TIMEOUT : GAP;
  localparam int CNT_W   = $clog2(CNT_MAX + 1);

  localparam logic [CNT_W-1:0] GAP_LAST     = CNT_W'(GAP - 1);
  localparam logic [CNT_W-1:0] TIMEOUT_LAST = CNT_W'(TIMEOUT - 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_SEND_LO,
    S_GAP,
    S_SEND_HI,
    S_WAIT_RSP,
    S_RESPOND
  } state_t;

  state_t           state;
  cmd_word_t        cmd_buf;
  logic [CNT_W-1:0] cnt;      // gap and reply timeout share this
  logic             started;  // reply start bit confirmed
  logic             accept;
  logic             timed_out;

  assign cmd_rdy   = (state == S_IDLE) || (state == S_RESPOND);
  assign accept    = cmd_vld && cmd_rdy;
  assign rx_en     = (state == S_WAIT_RSP);
  assign rsp_valid = (state == S_RESPOND);
  assign tx_byte   = (state == S_SEND_HI) ? {cmd_buf.wr, cmd_buf.addr} : cmd_buf.data;
  assign timed_out = !started && !rx_start_seen && (cnt == TIMEOUT_LAST);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= S_IDLE;
      tx_start <= 1'b0;
      cnt      <= '0;
      started  <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      case (state)
        S_IDLE, S_RESPOND:
          if (accept)
          begin
            state    <= S_SEND_LO;
            tx_start <= 1'b1;
          end
          else
            state <= S_IDLE;
        S_SEND_LO:
          if (tx_done)
          begin
            state <= S_GAP;
            cnt   <= CNT_W'(1);  // first gap cycle follows tx_done
          end
        S_GAP:
          if (cnt == GAP_LAST)
          begin
            state    <= S_SEND_HI;
            tx_start <= 1'b1;
          end
          else
            cnt <= cnt + CNT_W'(1);
        S_SEND_HI:
          if (tx_done)
          begin
            if (cmd_buf.wr)
              state <= S_IDLE;  // writes get no reply
            else
            begin
              state   <= S_WAIT_RSP;
              cnt     <= '0;
              started <= 1'b0;
            end
          end
        S_WAIT_RSP:
        begin
          if (rx_start_seen)
            started <= 1'b1;
          if (rx_valid || timed_out)
            state <= S_RESPOND;
          else if (!started)
            cnt <= cnt + CNT_W'(1);
        end
        default:
          state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_buf <= cmd_in;
    if (state == S_WAIT_RSP)
    begin
      if (timed_out)
      begin
        rsp_data   <= '0;
        rsp_status <= RSP_TIMEOUT;
      end
      else if (rx_valid)
      begin
        rsp_data <= rx_byte;
        if (rx_parity_err)
          rsp_status <= RSP_PARITY_ERR;  // parity wins over framing
        else if (rx_frame_err)
          rsp_status <= RSP_FRAME_ERR;
        else
          rsp_status <= RSP_OK;
      end
    end
  end

  // gap must cover the tail of the first frame
  assert property (@(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy)
    else $error("tx_start while transmitter busy");

  assert property (@(posedge clk) disable iff (!rst_n) rsp_valid |=> !rsp_valid)
    else $error("rsp_valid longer than one cycle");

endmodule

// ==== hw/cmd_uart_top.sv ====
`timescale 1ns/100ps

module cmd_uart_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  cmd_uart_pkg::cmd_word_t   cmd_in,
  input  logic                      cmd_vld,
  output logic                      cmd_rdy,
  output logic                      rsp_valid,
  output cmd_uart_pkg::uart_byte_t  rsp_data,
  output cmd_uart_pkg::rsp_status_t rsp_status,
  output logic                      tx,
  input  logic                      rx
);
  import cmd_uart_pkg::*;

  logic       tx_start;
  uart_byte_t tx_byte;
  logic       tx_busy;
  logic       tx_done;
  logic       rx_en;
  logic       rx_start_seen;
  logic       rx_valid;
  uart_byte_t rx_byte;
  logic       rx_parity_err;
  logic       rx_frame_err;

  cmd_ctrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_in        (cmd_in),
    .cmd_vld       (cmd_vld),
    .tx_busy       (tx_busy),
    .tx_done       (tx_done),
    .rx_start_seen (rx_start_seen),
    .rx_valid      (rx_valid),
    .rx_byte       (rx_byte),
    .rx_parity_err (rx_parity_err),
    .rx_frame_err  (rx_frame_err),
    .cmd_rdy       (cmd_rdy),
    .tx_start      (tx_start),
    .tx_byte       (tx_byte),
    .rx_en         (rx_en),
    .rsp_valid     (rsp_valid),
    .rsp_data      (rsp_data),
    .rsp_status    (rsp_status)
  );

  uart_tx u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy),
    .tx_done  (tx_done)
  );

  uart_rx u_rx (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx            (rx),
    .rx_en         (rx_en),
    .rx_start_seen (rx_start_seen),
    .rx_valid      (rx_valid),
    .rx_byte       (rx_byte),
    .rx_parity_err (rx_parity_err),
    .rx_frame_err  (rx_frame_err)
  );

endmodule

// ==== tb/cmd_uart_tb.sv ====
`timescale 1ns/100ps
`include "cmd_uart_config.svh"

module cmd_uart_tb;
  import cmd_uart_pkg::*;

  localparam int     CPB         = `CMD_UART_CLKS_PER_BIT;
  localparam int     TIMEOUT     = `CMD_UART_RESP_TIMEOUT;
  localparam int     PERIOD      = 40;
  localparam int     N_WR        = 10;
  localparam int     N_FRESH     = 4;
  localparam int     N_CMDS      = 2 * N_WR + N_FRESH + 6;
  localparam longint WATCHDOG_NS = longint'(N_CMDS + 1) * (30 * CPB + TIMEOUT) * PERIOD;

  localparam int FAULT_NONE   = 0;
  localparam int FAULT_PARITY = 1;
  localparam int FAULT_STOP   = 2;
  localparam int FAULT_SILENT = 3;

  logic        clk;
  logic        rst_n;
  cmd_word_t   cmd_in;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        rsp_valid;
  uart_byte_t  rsp_data;
  rsp_status_t rsp_status;
  logic        tx;
  logic        rx;
  logic [4:0]  reply_bits;
  logic        bad_parity;
  logic        low_stop;
  logic        silent;
  int          peer_cmds;
  int          peer_errs;

  logic [7:0]  shadow [0:127];  // expected peer contents
  logic        written [0:127];
  logic [6:0]  wr_addr [0:N_WR-1];
  logic [9:0]  exp_q [$];       // {status, data} per read
  logic [9:0]  exp_rsp;
  logic [6:0]  addr;
  int          idx;

  cmd_uart_top DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .cmd_rdy    (cmd_rdy),
    .rsp_valid  (rsp_valid),
    .rsp_data   (rsp_data),
    .rsp_status (rsp_status),
    .tx         (tx),
    .rx         (rx)
  );

  uart_peer u_peer (
    .clk        (clk),
    .line_in    (tx),
    .line_out   (rx),
    .reply_bits (reply_bits),
    .bad_parity (bad_parity),
    .low_stop   (low_stop),
    .silent     (silent),
    .cmd_count  (peer_cmds),
    .err_count  (peer_errs)
  );

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected)
      stop_run($sformatf("[FAIL] %0d ns %s: got 0x%0h, expected 0x%0h",
                         $time, what, actual, expected));
  endtask

  // expected {status, data} for a read, from the shadow copy
  function automatic logic [9:0] expected_reply(input logic [6:0] a, input int fault);
    rsp_status_t st;
    case (fault)
      FAULT_PARITY: st = RSP_PARITY_ERR;
      FAULT_STOP:   st = RSP_FRAME_ERR;
      FAULT_SILENT: st = RSP_TIMEOUT;
      default:      st = RSP_OK;
    endcase
    return {st, shadow[a]};
  endfunction

  task automatic step_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic run_cmd(input logic wr, input logic [6:0] a, input logic [7:0] data,
                         input int fault, input int hold);
    int peer_before;
    peer_before = peer_cmds;
    while (!cmd_rdy)
      step_cycle();
    bad_parity = (fault == FAULT_PARITY);
    low_stop   = (fault == FAULT_STOP);
    silent     = (fault == FAULT_SILENT);
    reply_bits = 5'($urandom_range(1, 20));
    if (!wr)
      exp_q.push_back(expected_reply(a, fault));
    cmd_in  = '{wr: wr, addr: a, data: data};
    cmd_vld = 1'b1;
    step_cycle();
    // cmd_vld left high while busy
    repeat (hold)
    begin
      check_equal(32'(cmd_rdy), 32'd0, "cmd_rdy while busy");
      step_cycle();
    end
    cmd_vld = 1'b0;
    if (wr)
    begin
      shadow[a]  = data;
      written[a] = 1'b1;
    end
    while (!cmd_rdy)
      step_cycle();
    check_equal(32'(peer_cmds), 32'(peer_before + 1), "peer command count");
    check_equal(32'(peer_errs), 32'd0, "peer frame errors");
    repeat ($urandom_range(0, 4))
      step_cycle();
  endtask

  // response checker
  always @(negedge clk)
  begin
    if (rst_n && rsp_valid)
    begin
      if (exp_q.size() == 0)
        stop_run("rsp_valid seen with no read outstanding");
      else
      begin
        exp_rsp = exp_q.pop_front();
        check_equal(32'(rsp_status), 32'(exp_rsp[9:8]), "rsp_status");
        if (exp_rsp[9:8] != RSP_TIMEOUT)
          check_equal(32'(rsp_data), 32'(exp_rsp[7:0]), "rsp_data");
      end
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    stop_run($sformatf("timeout: run did not finish within %0d ns", WATCHDOG_NS));
  end

  initial
  begin
    void'($urandom(32'h5dda));
    rst_n      = 1'b0;
    cmd_in     = '0;
    cmd_vld    = 1'b0;
    reply_bits = 5'd1;
    bad_parity = 1'b0;
    low_stop   = 1'b0;
    silent     = 1'b0;
    for (idx = 0; idx < 128; idx++)
    begin
      shadow[idx]  = 8'(idx) ^ 8'h5a;
      written[idx] = 1'b0;
    end
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    repeat (8)
    begin
      check_equal(32'(cmd_rdy), 32'd1, "cmd_rdy after reset");
      check_equal(32'(tx), 32'd1, "tx idle after reset");
      check_equal(32'(rsp_valid), 32'd0, "rsp_valid after reset");
      step_cycle();
    end

    for (idx = 0; idx < N_WR; idx++)
    begin
      wr_addr[idx] = 7'($urandom_range(0, 127));
      run_cmd(1'b1, wr_addr[idx], 8'($urandom), FAULT_NONE, 0);
    end
    for (idx = 0; idx < N_WR; idx++)
      run_cmd(1'b0, wr_addr[idx], 8'h00, FAULT_NONE, 0);
    for (idx = 0; idx < N_FRESH; idx++)
    begin
      do
        addr = 7'($urandom_range(0, 127));
      while (written[addr]);
      run_cmd(1'b0, addr, 8'h00, FAULT_NONE, 0);
    end

    addr = 7'($urandom_range(0, 127));
    run_cmd(1'b1, addr, 8'($urandom), FAULT_NONE, 50);
    run_cmd(1'b0, addr, 8'h00, FAULT_NONE, 0);

    run_cmd(1'b0, wr_addr[0], 8'h00, FAULT_PARITY, 0);
    run_cmd(1'b0, wr_addr[1], 8'h00, FAULT_STOP, 0);
    run_cmd(1'b0, wr_addr[2], 8'h00, FAULT_SILENT, 0);
    run_cmd(1'b0, wr_addr[2], 8'h00, FAULT_NONE, 0);  // recovers after timeout

    repeat (4 * CPB)
      step_cycle();
    check_equal(32'(exp_q.size()), 32'd0, "reads left without response");
    $display("** PASS **");
    $finish;
  end

endmodule

// ==== tb/uart_peer.sv ====
`timescale 1ns/100ps
`include "cmd_uart_config.svh"

module uart_peer (
  input  logic       clk,
  input  logic       line_in,     // from DUT tx
  output logic       line_out,    // to DUT rx
  input  logic [4:0] reply_bits,  // reply delay in bit periods
  input  logic       bad_parity,
  input  logic       low_stop,
  input  logic       silent,
  output int         cmd_count,
  output int         err_count
);
  localparam int CPB = `CMD_UART_CLKS_PER_BIT;

  logic [7:0] regs [0:127];
  logic [7:0] lo_byte;
  logic [7:0] hi_byte;
  logic       ok_lo;
  logic       ok_hi;
  logic [6:0] reply_addr;
  int         idx;
  event       reply_req;

  // all sampling and driving on the falling clock edge
  task automatic recv_frame(output logic [7:0] data, output logic ok);
    int   i;
    logic par;
    logic stop;
    @(negedge line_in);
    repeat (CPB / 2) @(negedge clk);
    ok = !line_in;  // start bit still low at its middle
    for (i = 0; i < 8; i++)
    begin
      repeat (CPB) @(negedge clk);
      data[i] = line_in;
    end
    repeat (CPB) @(negedge clk);
    par = line_in;
    repeat (CPB) @(negedge clk);
    stop = line_in;
    if (^{data, par} != 1'b1)
      ok = 1'b0;
    if (!stop)
      ok = 1'b0;
  endtask

  task automatic send_frame(input logic [7:0] data, input logic flip_par, input logic stop_val);
    int i;
    line_out = 1'b0;
    repeat (CPB) @(negedge clk);
    for (i = 0; i < 8; i++)
    begin
      line_out = data[i];
      repeat (CPB) @(negedge clk);
    end
    line_out = ~(^data) ^ flip_par;
    repeat (CPB) @(negedge clk);
    line_out = stop_val;
    repeat (CPB) @(negedge clk);
    line_out = 1'b1;
  endtask

  initial
  begin
    line_out  = 1'b1;
    cmd_count = 0;
    err_count = 0;
    for (idx = 0; idx < 128; idx++)
      regs[idx] = 8'(idx) ^ 8'h5a;
    forever
    begin
      recv_frame(lo_byte, ok_lo);
      recv_frame(hi_byte, ok_hi);
      cmd_count = cmd_count + 1;
      if (!ok_lo || !ok_hi)
        err_count = err_count + 1;
      if (hi_byte[7])
        regs[hi_byte[6:0]] = lo_byte;
      else
      begin
        reply_addr = hi_byte[6:0];
        -> reply_req;
      end
    end
  end

  // replies run apart so the next command frame is never missed
  initial
  begin
    forever
    begin
      @(reply_req);
      repeat (int'(reply_bits) * CPB) @(negedge clk);
      if (!silent)
        send_frame(regs[reply_addr], bad_parity, !low_stop);
    end
  end

endmodule

// ==== uart/uart_rx.sv ====
`timescale 1ns/100ps
`include "cmd_uart_config.svh"

module uart_rx (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     rx,
  input  logic                     rx_en,
  output logic                     rx_start_seen,
  output logic                     rx_valid,
  output cmd_uart_pkg::uart_byte_t rx_byte,
  output logic                     rx_parity_err,
  output logic                     rx_frame_err
);
  import cmd_uart_pkg::*;

  localparam int CPB   = `CMD_UART_CLKS_PER_BIT;
  localparam int CNT_W = $clog2(CPB);

  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CPB - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CPB / 2 - 1);

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_t;

  rx_state_t        state;
  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  logic             par_bit;
  logic             fall;
  logic             bit_end;

  assign fall    = rx_prev && !rx_sync;
  assign bit_end = (clk_cnt == BIT_LAST);

  // two flops against metastability, third one for edge detect
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state         <= RX_IDLE;
      clk_cnt       <= '0;
      bit_idx       <= '0;
      rx_start_seen <= 1'b0;
      rx_valid      <= 1'b0;
    end
    else
    begin
      rx_start_seen <= 1'b0;
      rx_valid      <= 1'b0;
      if (!rx_en)
        state <= RX_IDLE;
      else
      begin
        case (state)
          RX_IDLE:
            if (fall)
            begin
              state   <= RX_START;
              clk_cnt <= '0;
            end
          RX_START:
            if (clk_cnt == HALF_LAST)
            begin
              clk_cnt <= '0;
              if (!rx_sync)
              begin
                state         <= RX_DATA;
                bit_idx       <= '0;
                rx_start_seen <= 1'b1;
              end
              else
                state <= RX_IDLE;  // glitch, not a start bit
            end
            else
              clk_cnt <= clk_cnt + CNT_W'(1);
          RX_DATA:
            if (bit_end)
            begin
              clk_cnt <= '0;
              if (bit_idx == 3'd7)
                state <= RX_PARITY;
              else
                bit_idx <= bit_idx + 3'd1;
            end
            else
              clk_cnt <= clk_cnt + CNT_W'(1);
          RX_PARITY:
            if (bit_end)
            begin
              clk_cnt <= '0;
              state   <= RX_STOP;
            end
            else
              clk_cnt <= clk_cnt + CNT_W'(1);
          RX_STOP:
            if (bit_end)
            begin
              clk_cnt  <= '0;
              state    <= RX_IDLE;
              rx_valid <= 1'b1;
            end
            else
              clk_cnt <= clk_cnt + CNT_W'(1);
          default:
            state <= RX_IDLE;
        endcase
      end
    end
  end

  // mid-bit samples, lsb first
  always_ff @(posedge clk)
  begin
    if (rx_en && bit_end)
    begin
      case (state)
        RX_DATA:
          rx_byte <= {rx_sync, rx_byte[7:1]};
        RX_PARITY:
          par_bit <= rx_sync;
        RX_STOP:
        begin
          rx_parity_err <= (odd_parity(rx_byte) != par_bit);
          rx_frame_err  <= !rx_sync;  // stop bit must be high
        end
        default:
          par_bit <= par_bit;
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) rx_valid |=> !rx_valid)
    else $error("rx_valid longer than one cycle");

endmodule

// ==== uart/uart_tx.sv ====
`timescale 1ns/100ps
`include "cmd_uart_config.svh"

module uart_tx (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     tx_start,
  input  cmd_uart_pkg::uart_byte_t tx_byte,
  output logic                     tx,
  output logic                     tx_busy,
  output logic                     tx_done
);
  import cmd_uart_pkg::*;

  localparam int CPB   = `CMD_UART_CLKS_PER_BIT;
  localparam int CNT_W = $clog2(CPB);

  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CPB - 1);
  localparam logic [3:0]       STOP_IDX = 4'd10;

  logic [CNT_W-1:0] clk_cnt;
  logic [3:0]       bit_idx;  // 0 start, 1..8 data, 9 parity, 10 stop
  logic [9:0]       shreg;    // data, parity, stop still to send
  logic             bit_end;

  assign bit_end = (clk_cnt == BIT_LAST);
  assign tx_done = tx_busy && bit_end && (bit_idx == STOP_IDX);

  always_ff @(posedge clk)
  begin
    if (tx_start && !tx_busy)
      shreg <= {1'b1, odd_parity(tx_byte), tx_byte};
    else if (tx_busy && bit_end)
      shreg <= {1'b1, shreg[9:1]};
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx      <= 1'b1;
      tx_busy <= 1'b0;
      clk_cnt <= '0;
      bit_idx <= '0;
    end
    else if (!tx_busy)
    begin
      if (tx_start)
      begin
        tx      <= 1'b0;  // start bit
        tx_busy <= 1'b1;
        clk_cnt <= '0;
        bit_idx <= '0;
      end
    end
    else if (bit_end)
    begin
      clk_cnt <= '0;
      if (bit_idx == STOP_IDX)
      begin
        tx      <= 1'b1;
        tx_busy <= 1'b0;
      end
      else
      begin
        tx      <= shreg[0];
        bit_idx <= bit_idx + 4'd1;
      end
    end
    else
      clk_cnt <= clk_cnt + CNT_W'(1);
  end

  assert property (@(posedge clk) disable iff (!rst_n) !tx_busy |-> tx)
    else $error("tx low outside a frame");

endmodule
